// File: fifo_cfg_pkg.sv
// fifo geometry constants and gray/binary pointer conversion functions

package fifo_cfg_pkg;

    // ----------------------------------------
    // geometry
    // ----------------------------------------

    // memory address width
    localparam int addr_w = 4;

    // pointers carry one extra wrap bit above the address
    localparam int ptr_w = addr_w + 1;

    // entry count kept at pointer width so flag math needs no casts
    localparam logic [ptr_w-1:0] depth = ptr_w'(1 << addr_w);

    // almost flags rise when the distance is at or below this
    localparam logic [ptr_w-1:0] almost_gap = ptr_w'(3);

    // ----------------------------------------
    // pointer encoding
    // ----------------------------------------

    // binary to gray
    // neighbouring values differ in exactly one bit
    function automatic logic [ptr_w-1:0] bin2gray(input logic [ptr_w-1:0] bin);
        return (bin >> 1) ^ bin;
    endfunction

    // gray to binary
    // each bit is the xor of all gray bits at and above it
    function automatic logic [ptr_w-1:0] gray2bin(input logic [ptr_w-1:0] gray);
        logic [ptr_w-1:0] bin;
        bin[ptr_w-1] = gray[ptr_w-1];
        for (int i = ptr_w - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

// File: fifo_word_pkg.sv
// payload word type moved through the fifo and its field widths

package fifo_word_pkg;

    // ----------------------------------------
    // field widths
    // ----------------------------------------

    // data field of one word
    localparam int data_w = 8;

    // tag field travels with the data
    // lets the sink tell streams apart
    localparam int tag_w = 4;

    // ----------------------------------------
    // payload
    // ----------------------------------------

    // tag sits in the upper bits
    // data fills the low bits
    // 12 bits in total
    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] data;
    } word_t;

    // the memory stores this as an opaque entry
    // only the top and the testbench look inside

endpackage

// File: fifo_mem.sv
// dual-port fifo storage with synchronous write and asynchronous read

`timescale 1ns/10ps

module fifo_mem #(
    // payload stored in each entry
    parameter type entry_t = logic
) (
    // write side
    input  logic                           wclk,
    input  logic                           wen,
    input  logic [fifo_cfg_pkg::addr_w-1:0] waddr,
    input  entry_t                         wdata,
    // read side
    input  logic [fifo_cfg_pkg::addr_w-1:0] raddr,
    output entry_t                         rdata
);

    // ----------------------------------------
    // storage array
    // ----------------------------------------

    // plain register file
    // contents hold no meaning until written
    entry_t mem [fifo_cfg_pkg::depth];

    // ----------------------------------------
    // write port
    // ----------------------------------------

    // wen already excludes writes into a full fifo
    always_ff @(posedge wclk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // ----------------------------------------
    // read port
    // ----------------------------------------

    // combinational read from the current read address
    // the head word shows here while the fifo is not empty
    assign rdata = mem[raddr];

endmodule

// File: wptr_full.sv
// write pointer, read pointer synchronizer, full and almost-full flags

`timescale 1ns/10ps

module wptr_full (
    input  logic                           wclk,
    input  logic                           wrst_n,
    // write request from the source
    input  logic                           winc,
    // gray read pointer from the rclk domain
    input  logic [fifo_cfg_pkg::ptr_w-1:0]  rptr,
    // accepted write strobe to the memory
    output logic                           wen,
    output logic [fifo_cfg_pkg::addr_w-1:0] waddr,
    // gray write pointer toward the rclk domain
    output logic [fifo_cfg_pkg::ptr_w-1:0]  wptr,
    output logic                           wfull,
    output logic                           almost_full
);

    // ----------------------------------------
    // local signals
    // ----------------------------------------

    // binary write pointer and its next value
    logic [fifo_cfg_pkg::ptr_w-1:0] wbin;
    logic [fifo_cfg_pkg::ptr_w-1:0] wbin_next;
    logic [fifo_cfg_pkg::ptr_w-1:0] wgray_next;

    // two flop synchronizer stages for rptr
    logic [fifo_cfg_pkg::ptr_w-1:0] wq1_rptr;
    logic [fifo_cfg_pkg::ptr_w-1:0] wq2_rptr;

    // flag terms
    logic [fifo_cfg_pkg::ptr_w-1:0] full_cmp;
    logic [fifo_cfg_pkg::ptr_w-1:0] rsync_bin;
    logic [fifo_cfg_pkg::ptr_w-1:0] wused;
    logic [fifo_cfg_pkg::ptr_w-1:0] wfree;
    logic                           wfull_val;
    logic                           almost_full_val;

    // ----------------------------------------
    // read pointer synchronizer
    // ----------------------------------------

    // gray code keeps the capture off by at most one step
    always_ff @(posedge wclk or negedge wrst_n) begin
        if (!wrst_n) begin
            wq1_rptr <= '0;
            wq2_rptr <= '0;
        end else begin
            wq1_rptr <= rptr;
            wq2_rptr <= wq1_rptr;
        end
    end

    // ----------------------------------------
    // write pointer
    // ----------------------------------------

    // a write counts only while not full
    assign wen = winc & ~wfull;

    assign wbin_next  = wbin + {{(fifo_cfg_pkg::ptr_w-1){1'b0}}, wen};
    assign wgray_next = fifo_cfg_pkg::bin2gray(wbin_next);

    always_ff @(posedge wclk or negedge wrst_n) begin
        if (!wrst_n) begin
            wbin <= '0;
            wptr <= '0;
        end else begin
            wbin <= wbin_next;
            wptr <= wgray_next;
        end
    end

    // memory address drops the wrap bit
    assign waddr = wbin[fifo_cfg_pkg::addr_w-1:0];

    // ----------------------------------------
    // full flag
    // ----------------------------------------

    // full when write is one lap ahead of read
    // in gray that means the top two bits differ and the rest match
    assign full_cmp = {~wq2_rptr[fifo_cfg_pkg::ptr_w-1:fifo_cfg_pkg::ptr_w-2],
                       wq2_rptr[fifo_cfg_pkg::ptr_w-3:0]};
    assign wfull_val = (wgray_next == full_cmp);

    // ----------------------------------------
    // almost-full flag
    // ----------------------------------------

    // decode the stale read pointer and measure free space
    // a stale read pointer only makes the count look fuller
    assign rsync_bin = fifo_cfg_pkg::gray2bin(wq2_rptr);
    assign wused     = wbin_next - rsync_bin;
    assign wfree     = fifo_cfg_pkg::depth - wused;
    assign almost_full_val = (wfree <= fifo_cfg_pkg::almost_gap);

    always_ff @(posedge wclk or negedge wrst_n) begin
        if (!wrst_n) begin
            wfull       <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            wfull       <= wfull_val;
            almost_full <= almost_full_val;
        end
    end

endmodule

// File: rptr_empty.sv
// read pointer, write pointer synchronizer, empty and almost-empty flags

`timescale 1ns/10ps

module rptr_empty (
    input  logic                           rclk,
    input  logic                           rrst_n,
    // read request from the sink
    input  logic                           rinc,
    // gray write pointer from the wclk domain
    input  logic [fifo_cfg_pkg::ptr_w-1:0]  wptr,
    output logic [fifo_cfg_pkg::addr_w-1:0] raddr,
    // gray read pointer toward the wclk domain
    output logic [fifo_cfg_pkg::ptr_w-1:0]  rptr,
    output logic                           rempty,
    output logic                           almost_empty
);

    // ----------------------------------------
    // local signals
    // ----------------------------------------

    // accepted read
    logic                           ren;

    // binary read pointer and its next value
    logic [fifo_cfg_pkg::ptr_w-1:0] rbin;
    logic [fifo_cfg_pkg::ptr_w-1:0] rbin_next;
    logic [fifo_cfg_pkg::ptr_w-1:0] rgray_next;

    // two flop synchronizer stages for wptr
    logic [fifo_cfg_pkg::ptr_w-1:0] rq1_wptr;
    logic [fifo_cfg_pkg::ptr_w-1:0] rq2_wptr;

    // flag terms
    logic [fifo_cfg_pkg::ptr_w-1:0] wsync_bin;
    logic [fifo_cfg_pkg::ptr_w-1:0] rused;
    logic                           rempty_val;
    logic                           almost_empty_val;

    // ----------------------------------------
    // write pointer synchronizer
    // ----------------------------------------

    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            rq1_wptr <= '0;
            rq2_wptr <= '0;
        end else begin
            rq1_wptr <= wptr;
            rq2_wptr <= rq1_wptr;
        end
    end

    // ----------------------------------------
    // read pointer
    // ----------------------------------------

    // reads against an empty fifo are ignored
    assign ren = rinc & ~rempty;

    assign rbin_next  = rbin + {{(fifo_cfg_pkg::ptr_w-1){1'b0}}, ren};
    assign rgray_next = fifo_cfg_pkg::bin2gray(rbin_next);

    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            rbin <= '0;
            rptr <= '0;
        end else begin
            rbin <= rbin_next;
            rptr <= rgray_next;
        end
    end

    // binary is safe for the local address
    assign raddr = rbin[fifo_cfg_pkg::addr_w-1:0];

    // ----------------------------------------
    // empty flag
    // ----------------------------------------

    // empty once the next read pointer catches the seen write pointer
    assign rempty_val = (rgray_next == rq2_wptr);

    // ----------------------------------------
    // almost-empty flag
    // ----------------------------------------

    // occupancy from the decoded write pointer
    // a stale write pointer only makes the count look emptier
    assign wsync_bin = fifo_cfg_pkg::gray2bin(rq2_wptr);
    assign rused     = wsync_bin - rbin_next;
    assign almost_empty_val = (rused <= fifo_cfg_pkg::almost_gap);

    // both flags come up set out of reset
    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            rempty       <= 1'b1;
            almost_empty <= 1'b1;
        end else begin
            rempty       <= rempty_val;
            almost_empty <= almost_empty_val;
        end
    end

endmodule

// File: async_fifo.sv
// top level of the dual-clock fifo joining memory and pointer blocks

`timescale 1ns/10ps

module async_fifo (
    // write domain
    input  logic                 wclk,
    input  logic                 wrst_n,
    input  logic                 winc,
    input  fifo_word_pkg::word_t wdata,
    // read domain
    input  logic                 rclk,
    input  logic                 rrst_n,
    input  logic                 rinc,
    // head word valid while rempty is low
    output fifo_word_pkg::word_t rdata,
    // status flags
    output logic                 wfull,
    output logic                 almost_full,
    output logic                 rempty,
    output logic                 almost_empty
);

    // ----------------------------------------
    // internal wiring
    // ----------------------------------------

    logic                            wen;
    logic [fifo_cfg_pkg::addr_w-1:0] waddr;
    logic [fifo_cfg_pkg::addr_w-1:0] raddr;

    // gray pointers crossing between domains
    logic [fifo_cfg_pkg::ptr_w-1:0]  wptr;
    logic [fifo_cfg_pkg::ptr_w-1:0]  rptr;

    // ----------------------------------------
    // storage
    // ----------------------------------------

    fifo_mem #(
        .entry_t (fifo_word_pkg::word_t)
    ) mem_i (
        .wclk  (wclk),
        .wen   (wen),
        .waddr (waddr),
        .wdata (wdata),
        .raddr (raddr),
        .rdata (rdata)
    );

    // ----------------------------------------
    // write side pointer and flags
    // ----------------------------------------

    wptr_full wptr_i (
        .wclk        (wclk),
        .wrst_n      (wrst_n),
        .winc        (winc),
        .rptr        (rptr),
        .wen         (wen),
        .waddr       (waddr),
        .wptr        (wptr),
        .wfull       (wfull),
        .almost_full (almost_full)
    );

    // ----------------------------------------
    // read side pointer and flags
    // ----------------------------------------

    rptr_empty rptr_i (
        .rclk         (rclk),
        .rrst_n       (rrst_n),
        .rinc         (rinc),
        .wptr         (wptr),
        .raddr        (raddr),
        .rptr         (rptr),
        .rempty       (rempty),
        .almost_empty (almost_empty)
    );

endmodule

// File: async_fifo_chk.sv
// concurrent assertions on fifo pointers and flags, bound into the top level

`timescale 1ns/10ps

module async_fifo_chk (
    input logic                           wclk,
    input logic                           wrst_n,
    input logic                           rclk,
    input logic                           rrst_n,
    input logic [fifo_cfg_pkg::ptr_w-1:0] wptr,
    input logic [fifo_cfg_pkg::ptr_w-1:0] rptr,
    input logic                           wfull,
    input logic                           almost_full,
    input logic                           rempty,
    input logic                           almost_empty
);

    // count of failed assertions
    int failures = 0;

    // ----------------------------------------
    // write domain
    // ----------------------------------------

    // no write gets through a full fifo
    assert property (@(posedge wclk) disable iff (!wrst_n) wfull |=> $stable(wptr))
        else begin
            $error("write pointer moved while full");
            failures++;
        end

    // gray pointer steps one bit at a time
    assert property (@(posedge wclk) disable iff (!wrst_n)
                     $countones(wptr ^ $past(wptr)) <= 1)
        else begin
            $error("write gray pointer changed more than one bit");
            failures++;
        end

    assert property (@(posedge wclk) disable iff (!wrst_n) wfull |-> almost_full)
        else begin
            $error("full without almost full");
            failures++;
        end

    // ----------------------------------------
    // read domain
    // ----------------------------------------

    assert property (@(posedge rclk) disable iff (!rrst_n) rempty |=> $stable(rptr))
        else begin
            $error("read pointer moved while empty");
            failures++;
        end

    assert property (@(posedge rclk) disable iff (!rrst_n)
                     $countones(rptr ^ $past(rptr)) <= 1)
        else begin
            $error("read gray pointer changed more than one bit");
            failures++;
        end

    assert property (@(posedge rclk) disable iff (!rrst_n) rempty |-> almost_empty)
        else begin
            $error("empty without almost empty");
            failures++;
        end

endmodule

// attach to every fifo top, reaching the internal gray pointers
bind async_fifo async_fifo_chk chk_i (
    .wclk         (wclk),
    .wrst_n       (wrst_n),
    .rclk         (rclk),
    .rrst_n       (rrst_n),
    .wptr         (wptr),
    .rptr         (rptr),
    .wfull        (wfull),
    .almost_full  (almost_full),
    .rempty       (rempty),
    .almost_empty (almost_empty)
);

// File: async_fifo_tb.sv
// testbench for the dual-clock fifo with reference queue model, comparison process and timeout

`timescale 1ns/10ps

module async_fifo_tb;

    // ----------------------------------------
    // run length
    // ----------------------------------------

    // fill and drain, level checks, random stream, reads while empty
    localparam int total_ops = 36 + 64 + 400 + 8;
    localparam int cycle_limit = 4 * total_ops + 200;
    localparam int fifo_depth = 16;
    localparam int gap = 3;

    // dut inputs
    logic                 wclk;
    logic                 rclk;
    logic                 wrst_n;
    logic                 rrst_n;
    logic                 winc;
    logic                 rinc;
    fifo_word_pkg::word_t wdata;

    // dut outputs
    fifo_word_pkg::word_t rdata;
    logic                 wfull;
    logic                 almost_full;
    logic                 rempty;
    logic                 almost_empty;

    // reference model state
    fifo_word_pkg::word_t model_q[$];
    fifo_word_pkg::word_t last_read;
    int                   reads_done;
    int                   seq;
    int                   cycles;
    integer               seed;
    string                test_name;

    async_fifo dut_i (
        .wclk         (wclk),
        .wrst_n       (wrst_n),
        .winc         (winc),
        .wdata        (wdata),
        .rclk         (rclk),
        .rrst_n       (rrst_n),
        .rinc         (rinc),
        .rdata        (rdata),
        .wfull        (wfull),
        .almost_full  (almost_full),
        .rempty       (rempty),
        .almost_empty (almost_empty)
    );

    // ----------------------------------------
    // clocks
    // ----------------------------------------

    always #2 wclk = ~wclk;
    always #3.5 rclk = ~rclk;

    // ----------------------------------------
    // reference functions
    // ----------------------------------------

    // oldest word still held in the fifo
    function automatic fifo_word_pkg::word_t expected_head();
        return model_q[0];
    endfunction

    // almost flags at rest follow the true occupancy
    function automatic logic expected_almost_empty(input int count);
        return count <= gap;
    endfunction

    function automatic logic expected_almost_full(input int count);
        return (fifo_depth - count) <= gap;
    endfunction

    // low tag bits follow the sequence so reorders show up
    function automatic fifo_word_pkg::word_t make_word(input int n, input int rnd);
        fifo_word_pkg::word_t w;
        w.tag  = n[fifo_word_pkg::tag_w-1:0];
        w.data = rnd[fifo_word_pkg::data_w-1:0];
        return w;
    endfunction

    // ----------------------------------------
    // checks and failure exits
    // ----------------------------------------

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            stop_run($sformatf("error %s %s expected %0h actual %0h",
                               test_name, what, expected, actual));
        end
    endtask

    // wclk cycle counter bounds the whole run
    // bound checker failures end it as well
    always @(posedge wclk) begin
        cycles++;
        if (dut_i.chk_i.failures != 0) begin
            stop_run({"concurrent assertion failed in ", test_name});
        end else if (cycles >= cycle_limit) begin
            stop_run($sformatf("timeout after %0d write clock cycles in %s", cycles, test_name));
        end
    end

    // ----------------------------------------
    // model updates and comparison
    // ----------------------------------------

    // accepted write pushes the word
    always @(posedge wclk) begin
        if (wrst_n && winc && !wfull) begin
            model_q.push_back(wdata);
        end
    end

    // accepted read must show the model head
    always @(posedge rclk) begin
        if (rrst_n && rinc && !rempty) begin
            if (model_q.size() == 0) begin
                stop_run({"read accepted while the model holds no word in ", test_name});
            end else begin
                check("read_data", 32'(expected_head()), 32'(rdata));
                last_read = rdata;
                void'(model_q.pop_front());
                reads_done++;
            end
        end
    end

    // ----------------------------------------
    // stimulus tasks
    // ----------------------------------------

    task automatic write_words(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge wclk);
            winc  = 1'b1;
            wdata = make_word(seq, $random(seed));
            seq++;
        end
        @(negedge wclk);
        winc = 1'b0;
    endtask

    // read until the model is empty
    task automatic drain();
        while (model_q.size() > 0) begin
            @(negedge rclk);
            rinc = (model_q.size() > 0);
        end
        rinc = 1'b0;
    endtask

    task automatic check_levels(input int count);
        write_words(count - model_q.size());
        repeat (10) @(posedge rclk);
        check("count", count, model_q.size());
        check("almost_empty", expected_almost_empty(count), almost_empty);
        check("almost_full", expected_almost_full(count), almost_full);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        int reads_before;
        fifo_word_pkg::word_t first_word;
        wclk = 1'b0;
        rclk = 1'b0;
        wrst_n = 1'b0;
        rrst_n = 1'b0;
        winc = 1'b0;
        rinc = 1'b0;
        wdata = '0;
        seed = 32'h5feb2ae2;
        seq = 0;
        cycles = 0;
        reads_done = 0;
        test_name = "reset";
        repeat (10) @(negedge wclk);
        wrst_n = 1'b1;
        rrst_n = 1'b1;
        repeat (2) @(negedge wclk);
        check("wfull", 0, wfull);
        check("almost_full", 0, almost_full);
        check("rempty", 1, rempty);
        check("almost_empty", 1, almost_empty);

        // 16 accepted writes then the extra four are dropped
        test_name = "fill";
        write_words(16);
        check("wfull", 1, wfull);
        write_words(4);
        check("count", 16, model_q.size());
        reads_before = reads_done;
        drain();
        @(negedge rclk);
        check("reads", 16, reads_done - reads_before);
        check("rempty", 1, rempty);

        test_name = "levels";
        check_levels(0);
        check_levels(2);
        check_levels(3);
        check_levels(4);
        check_levels(12);
        check_levels(13);
        check_levels(16);
        drain();

        // both sides toggle at random
        test_name = "stream";
        fork
            begin
                repeat (200) begin
                    @(negedge wclk);
                    winc  = $random(seed) & 1;
                    wdata = make_word(seq, $random(seed));
                    seq++;
                end
                @(negedge wclk);
                winc = 1'b0;
            end
            repeat (200) begin
                @(negedge rclk);
                rinc = $random(seed) & 1;
            end
        join
        drain();
        // no word left behind once the model is empty
        repeat (5) @(negedge rclk);
        check("rempty", 1, rempty);

        test_name = "read_empty";
        repeat (10) @(posedge rclk);
        reads_before = reads_done;
        repeat (5) begin
            @(negedge rclk);
            rinc = 1'b1;
            @(negedge rclk);
            rinc = 1'b0;
        end
        check("reads", 0, reads_done - reads_before);
        check("rempty", 1, rempty);
        write_words(1);
        first_word = model_q[0];
        while (rempty) @(posedge rclk);
        @(negedge rclk);
        rinc = 1'b1;
        @(negedge rclk);
        rinc = 1'b0;
        check("reads", 1, reads_done - reads_before);
        check("first_word", 32'(first_word), 32'(last_read));

        if (dut_i.chk_i.failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
fifo_cfg_pkg.sv
fifo_word_pkg.sv
fifo_mem.sv
wptr_full.sv
rptr_empty.sv
async_fifo.sv
async_fifo_chk.sv
async_fifo_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = async_fifo_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log

SRCS = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
